// ==== hw/ctrl_config.svh ====
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// ALU operation code width
`define CTRL_ALUCTRL_W 6

// N, Z, C, V
`define CTRL_FLAGS_W 4

// Condition field, instruction bits 31:28
`define CTRL_COND_W 4

// Destination register that aliases the program counter
`define CTRL_PC_REG 15

`endif

// ==== hw/ctrlPkg.sv ====
`include "ctrl_config.svh"

package ctrlPkg;

  typedef logic [`CTRL_ALUCTRL_W-1:0] aluCtrlT;

  // Fixed ALU codes outside the data-op space
  localparam aluCtrlT ALU_B         = 6'd0;
  localparam aluCtrlT ALU_BL        = 6'd1;
  localparam aluCtrlT ALU_MEM_BASE  = 6'd2;   // Memory sub-code offset
  localparam aluCtrlT ALU_BOF       = 6'd16;  // Branch on flags
  localparam aluCtrlT ALU_BLOF      = 6'd17;  // Branch-link on flags
  localparam aluCtrlT ALU_CBZ       = 6'd18;
  localparam aluCtrlT ALU_CBNZ      = 6'd19;
  localparam aluCtrlT ALU_MULDIV_LO = 6'h27;  // MUL
  localparam aluCtrlT ALU_MULDIV_HI = 6'h2F;  // SDIV
  localparam aluCtrlT ALU_MOV       = 6'h39;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Code 15 is treated as always
  typedef enum logic [`CTRL_COND_W-1:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC, HI, LS, GE, LT, GT, LE, AL
  } condT;

  typedef struct packed {
    logic [1:0] flagWrite;  // {NZ, CV}
    logic       branch;
    logic       memWrite;
    logic       regWrite;
    logic       pcSrc;
    logic       memtoReg;
    logic       aluSrc;
    aluCtrlT    aluCtrl;
    condT       cond;
  } ePayloadT;

  typedef struct packed {
    logic memWrite;
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } mPayloadT;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } wPayloadT;

endpackage

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module mainDecoder (
  input  logic [31:12] instr,
  output logic [1:0]   regSrc,
  output logic [1:0]   immSrc,
  output logic         aluSrc,
  output logic         memtoReg,
  output logic         regWrite,
  output logic         memWrite,
  output logic         branch,
  output logic         pcSrc,
  output logic         aluOp
);

  logic isData;
  logic isBranch;
  logic slBit;
  logic destIsPc;

  assign isData   = instr[27];
  assign isBranch = ~instr[27] & instr[26];  // Only meaningful outside data ops
  assign slBit    = instr[20];                // S on data, L on memory
  assign destIsPc = (instr[15:12] == 4'(`CTRL_PC_REG));

  always_comb begin
    regSrc   = 2'b00;
    immSrc   = 2'b00;
    aluSrc   = 1'b0;
    memtoReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    if (isData) begin
      aluSrc   = instr[25];  // Immediate operand
      regWrite = 1'b1;
    end else if (isBranch) begin
      regSrc = 2'b01;
      immSrc = 2'b10;
      branch = 1'b1;         // No memory write on branches
    end else begin
      // Load when L is set, store otherwise
      regSrc   = {~slBit, 1'b0};
      immSrc   = 2'b01;
      aluSrc   = 1'b1;
      memtoReg = slBit;
      regWrite = slBit;
      memWrite = ~slBit;
    end
  end

  assign aluOp = isData;
  assign pcSrc = branch | (regWrite & destIsPc);  // Branch or write to PC

endmodule

// ==== hw/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder
  import ctrlPkg::*;
(
  input  logic [31:12] instr,
  input  logic         aluOp,
  output aluCtrlT      aluControl,
  output logic [1:0]   flagWrite
);

  localparam logic [4:0] DATA_UNDEF = 5'b11111;

  logic [4:0] dataCode;
  logic [3:0] memCode;
  logic       sBit;
  logic       isMulDiv;
  logic       noCvUpdate;

  assign dataCode = {instr[26], instr[24:21]};
  assign memCode  = instr[24:21];
  assign sBit     = instr[20];

  always_comb begin
    if (aluOp) begin
      // Data op space 0x20 to 0x3E
      if (dataCode == DATA_UNDEF) begin
        aluControl = '0;
      end else begin
        aluControl = {1'b1, dataCode};
      end
    end else if (instr[26]) begin
      case (instr[25:24])
        2'b00:   aluControl = ALU_B;
        2'b01:   aluControl = ALU_BL;
        2'b11:   aluControl = ALU_CBZ;   // Test and branch
        default: aluControl = ALU_CBNZ;
      endcase
    end else begin
      case (memCode)
        4'd14:   aluControl = ALU_BOF;   // Moved off sub-code 4
        4'd15:   aluControl = ALU_BLOF;  // Moved off sub-code 5
        default: aluControl = {2'b00, memCode} + ALU_MEM_BASE;
      endcase
    end
  end

  // Multiply, divide, MOV and the undefined code leave C and V alone
  assign isMulDiv   = (aluControl >= ALU_MULDIV_LO) && (aluControl <= ALU_MULDIV_HI);
  assign noCvUpdate = isMulDiv || (aluControl == ALU_MOV) || (dataCode == DATA_UNDEF);

  assign flagWrite[1] = aluOp & sBit;                // N and Z
  assign flagWrite[0] = aluOp & sBit & ~noCvUpdate;  // C and V

endmodule

// ==== hw/condUnit.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module condUnit
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  condT       cond,
  input  flagsT      aluFlags,
  input  logic [1:0] flagWrite,
  output logic       condEx,
  output logic       carry
);

  flagsT                  flagsQ;
  flagsT                  flagsNext;
  logic [`CTRL_FLAGS_W-1:0] updMask;

  always_comb begin
    case (cond)
      EQ:      condEx = flagsQ.z;
      NE:      condEx = ~flagsQ.z;
      CS:      condEx = flagsQ.c;
      CC:      condEx = ~flagsQ.c;
      MI:      condEx = flagsQ.n;
      PL:      condEx = ~flagsQ.n;
      VS:      condEx = flagsQ.v;
      VC:      condEx = ~flagsQ.v;
      HI:      condEx = flagsQ.c & ~flagsQ.z;
      LS:      condEx = ~flagsQ.c | flagsQ.z;
      GE:      condEx = (flagsQ.n == flagsQ.v);
      LT:      condEx = (flagsQ.n != flagsQ.v);
      GT:      condEx = ~flagsQ.z & (flagsQ.n == flagsQ.v);
      LE:      condEx = flagsQ.z | (flagsQ.n != flagsQ.v);
      default: condEx = 1'b1;  // AL and code 15
    endcase
  end

  // High bit selects N and Z, low bit selects C and V
  assign updMask   = {flagWrite[1], flagWrite[1], flagWrite[0], flagWrite[0]};
  assign flagsNext = (flagsQ & ~updMask) | (aluFlags & updMask);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (condEx) begin
      flagsQ <= flagsNext;  // Skipped instructions keep the flags
    end
  end

  assign carry = flagsQ.c;

endmodule

// ==== hw/pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
  parameter type     payloadT  = logic,
  parameter payloadT clearMask = '1   // Bits zeroed by clear
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    en,
  input  logic    clear,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      q <= '0;
    end else if (clear) begin
      // Unmasked bits still follow en
      q <= en ? (d & ~clearMask) : (q & ~clearMask);
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// ==== hw/controlPipe.sv ====
`timescale 1ns/1ps

module controlPipe
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       flushE,
  input  condT       condD,
  input  flagsT      aluFlagsE,
  input  aluCtrlT    aluControlD,
  input  logic [1:0] flagWriteD,
  input  logic       branchD,
  input  logic       memWriteD,
  input  logic       regWriteD,
  input  logic       pcSrcD,
  input  logic       memtoRegD,
  input  logic       aluSrcD,
  output logic       aluSrcE,
  output aluCtrlT    aluControlE,
  output logic       branchTakenE,
  output logic       carryE,
  output logic       memtoRegE,
  output logic       memWriteM,
  output logic       regWriteM,
  output logic       memtoRegW,
  output logic       regWriteW,
  output logic       pcSrcW,
  output logic       pcWrPendingF
);

  // Flush kills control bits only, the operand fields pass through
  localparam ePayloadT E_CLEAR_MASK = '{
    flagWrite: 2'b11, branch: 1'b1, memWrite: 1'b1, regWrite: 1'b1,
    pcSrc: 1'b1, memtoReg: 1'b1, aluSrc: 1'b0, aluCtrl: '0, cond: condT'(0)
  };

  ePayloadT dE, qE;
  mPayloadT dM, qM;
  wPayloadT dW, qW;
  logic     condEx;

  assign dE = '{
    flagWrite: flagWriteD, branch: branchD, memWrite: memWriteD, regWrite: regWriteD,
    pcSrc: pcSrcD, memtoReg: memtoRegD, aluSrc: aluSrcD, aluCtrl: aluControlD, cond: condD
  };

  pipeReg #(.payloadT(ePayloadT), .clearMask(E_CLEAR_MASK)) execReg (
    .clk(clk), .rstN(rstN), .en(1'b1), .clear(flushE), .d(dE), .q(qE)
  );

  condUnit condU (
    .clk(clk), .rstN(rstN), .cond(qE.cond), .aluFlags(aluFlagsE),
    .flagWrite(qE.flagWrite), .condEx(condEx), .carry(carryE)
  );

  assign branchTakenE = qE.branch & condEx;
  assign dM = '{
    memWrite: qE.memWrite & condEx, memtoReg: qE.memtoReg,
    regWrite: qE.regWrite & condEx, pcSrc: qE.pcSrc & condEx
  };

  pipeReg #(.payloadT(mPayloadT)) memReg (
    .clk(clk), .rstN(rstN), .en(1'b1), .clear(1'b0), .d(dM), .q(qM)
  );

  assign dW = '{memtoReg: qM.memtoReg, regWrite: qM.regWrite, pcSrc: qM.pcSrc};

  pipeReg #(.payloadT(wPayloadT)) wbReg (
    .clk(clk), .rstN(rstN), .en(1'b1), .clear(1'b0), .d(dW), .q(qW)
  );

  assign aluSrcE     = qE.aluSrc;
  assign aluControlE = qE.aluCtrl;
  assign memtoRegE   = qE.memtoReg;
  assign memWriteM   = qM.memWrite;
  assign regWriteM   = qM.regWrite;
  assign memtoRegW   = qW.memtoReg;
  assign regWriteW   = qW.regWrite;
  assign pcSrcW      = qW.pcSrc;

  // Execute term is ungated, fetch stalls on any possible PC write
  assign pcWrPendingF = pcSrcD | qE.pcSrc | qM.pcSrc;

endmodule

// ==== hw/controller.sv ====
`timescale 1ns/1ps

module controller
  import ctrlPkg::*;
(
  input  logic         clk,
  input  logic         rstN,
  input  logic [31:12] instrD,
  input  flagsT        aluFlagsE,
  input  logic         flushE,
  output logic [1:0]   regSrcD,
  output logic [1:0]   immSrcD,
  output logic         aluSrcE,
  output logic         branchTakenE,
  output aluCtrlT      aluControlE,
  output logic         carryE,
  output logic         memWriteM,
  output logic         memtoRegW,
  output logic         pcSrcW,
  output logic         regWriteW,
  output logic         regWriteM,
  output logic         memtoRegE,
  output logic         pcWrPendingF
);

  aluCtrlT    aluControlD;
  logic [1:0] flagWriteD;
  logic       aluOpD;
  logic       aluSrcD;
  logic       memtoRegD;
  logic       regWriteD;
  logic       memWriteD;
  logic       branchD;
  logic       pcSrcD;

  mainDecoder mainDec (
    .instr(instrD), .regSrc(regSrcD), .immSrc(immSrcD), .aluSrc(aluSrcD),
    .memtoReg(memtoRegD), .regWrite(regWriteD), .memWrite(memWriteD),
    .branch(branchD), .pcSrc(pcSrcD), .aluOp(aluOpD)
  );

  aluDecoder aluDec (
    .instr(instrD), .aluOp(aluOpD), .aluControl(aluControlD), .flagWrite(flagWriteD)
  );

  controlPipe ctrlPipe (
    .clk(clk), .rstN(rstN), .flushE(flushE), .condD(condT'(instrD[31:28])),
    .aluFlagsE(aluFlagsE), .aluControlD(aluControlD), .flagWriteD(flagWriteD),
    .branchD(branchD), .memWriteD(memWriteD), .regWriteD(regWriteD), .pcSrcD(pcSrcD),
    .memtoRegD(memtoRegD), .aluSrcD(aluSrcD), .aluSrcE(aluSrcE),
    .aluControlE(aluControlE), .branchTakenE(branchTakenE), .carryE(carryE),
    .memtoRegE(memtoRegE), .memWriteM(memWriteM), .regWriteM(regWriteM),
    .memtoRegW(memtoRegW), .regWriteW(regWriteW), .pcSrcW(pcSrcW),
    .pcWrPendingF(pcWrPendingF)
  );

endmodule

// ==== verification/controller_asserts.sv ====
`timescale 1ns/1ps

module controller_asserts
  import ctrlPkg::*;
(
  input logic     clk,
  input logic     rstN,
  input logic     flushE,
  input logic     condEx,
  input mPayloadT qM,
  input wPayloadT qW,
  input logic     memWriteM
);

  // Skipped instruction leaves no write in Memory
  property noWriteWhenSkipped;
    @(posedge clk) disable iff (!rstN)
      !condEx |=> !(qM.memWrite || qM.regWrite || qM.pcSrc);
  endproperty

  property quietAfterReset;
    @(posedge clk) !rstN |=> (qM == '0) && (qW == '0);
  endproperty

  // Flushed in Execute, so nothing stored from Memory
  property flushBlocksStore;
    @(posedge clk) disable iff (!rstN)
      flushE |-> ##2 !memWriteM;
  endproperty

  assert property (noWriteWhenSkipped)
    else $error("Gated write reached Memory although the condition failed");
  assert property (quietAfterReset)
    else $error("Memory or Writeback enable set right after reset");
  assert property (flushBlocksStore)
    else $error("Memory write two cycles after a flush");

endmodule

// ==== verification/controller_tb.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module controller_tb
  import ctrlPkg::*;
();

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    ePayloadT   e;
  } decT;

  localparam int NUM_DIRECTED = 14;
  // Columns: instrD[31:12], aluFlagsE NZCV for the row before, flushE
  localparam logic [24:0] DIRECTED [NUM_DIRECTED] = '{
    {20'hE8901, 4'h0, 1'b0},  // ADDS sets Z and C
    {20'hE8F02, 4'h6, 1'b0},  // MULS keeps C and V
    {20'hED302, 4'h9, 1'b0},  // MOVS keeps C and V
    {20'h24000, 4'h0, 1'b0},  // BCS on kept carry
    {20'h03C04, 4'h0, 1'b0},  // STR sub-code 14, EQ
    {20'hE880F, 4'h0, 1'b0},  // ADD to PC
    {20'hE210F, 4'h0, 1'b0},  // LDR to PC
    {20'hE5000, 4'h0, 1'b0},  // BL
    {20'hE6000, 4'h0, 1'b0},  // CBNZ
    {20'hE7000, 4'h0, 1'b0},  // CBZ
    {20'hE3E04, 4'h0, 1'b1},  // STR sub-code 15, flushed
    {20'hE8901, 4'h0, 1'b1},  // Flushed ADDS
    {20'h1880F, 4'hF, 1'b0},  // ADDNE to PC, Z still clear
    {20'hEDF01, 4'h0, 1'b0}   // Undefined code with S
  };

  logic         clk = 1'b0;
  logic         rstN;
  logic [31:12] instrD;
  flagsT        aluFlagsE;
  logic         flushE;
  logic [1:0]   regSrcD, immSrcD;
  logic         aluSrcE, branchTakenE, carryE, memWriteM, memtoRegW, pcSrcW;
  logic         regWriteW, regWriteM, memtoRegE, pcWrPendingF;
  aluCtrlT      aluControlE;

  ePayloadT    eQ;  // Reference pipeline state
  mPayloadT    mQ;
  wPayloadT    wQ;
  flagsT       flagsRef;
  integer      seed;
  logic [31:0] rnd;
  int          cnt;
  bit          finished = 1'b0;

  controller uut (.*);

  bind controlPipe controller_asserts pipeChecks (
    .clk(clk), .rstN(rstN), .flushE(flushE), .condEx(condEx),
    .qM(qM), .qW(qW), .memWriteM(memWriteM)
  );

  always #5 clk = ~clk;

  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
  end

  function automatic logic [31:12] dataOp(input logic [3:0] cond, input logic [4:0] code,
                                          input logic imm, input logic s, input logic [3:0] rd);
    return {cond, 1'b1, code[4], imm, code[3:0], s, 4'h0, rd};
  endfunction

  function automatic logic [31:12] memOp(input logic [3:0] cond, input logic [3:0] sub,
                                         input logic ld, input logic [3:0] rd);
    return {cond, 2'b00, 1'b1, sub, ld, 4'h0, rd};
  endfunction

  function automatic logic [31:12] brOp(input logic [3:0] cond, input logic [1:0] kind);
    return {cond, 2'b01, kind, 12'h000};
  endfunction

  function automatic logic predictCond(input condT c, input flagsT f);
    logic ge;
    ge = (f.n == f.v);
    case (c)
      EQ: return f.z;
      NE: return !f.z;
      CS: return f.c;
      CC: return !f.c;
      MI: return f.n;
      PL: return !f.n;
      VS: return f.v;
      VC: return !f.v;
      HI: return f.c && !f.z;
      LS: return !f.c || f.z;
      GE: return ge;
      LT: return !ge;
      GT: return !f.z && ge;
      LE: return f.z || !ge;
      default: return 1'b1;
    endcase
  endfunction

  function automatic decT predictDecode(input logic [31:12] ins);
    decT        r;
    logic [4:0] code;
    logic [3:0] sub;
    r = '0;
    code = {ins[26], ins[24:21]};
    sub = ins[24:21];
    r.e.cond = condT'(ins[31:28]);
    if (ins[27]) begin
      r.e.aluSrc = ins[25];
      r.e.regWrite = 1'b1;
      r.e.aluCtrl = (code == 5'd31) ? 6'd0 : {1'b1, code};
      r.e.flagWrite[1] = ins[20];
      // MUL to SDIV, MOV and undefined keep C and V
      r.e.flagWrite[0] = ins[20] &&
          !((code >= 5'd7 && code <= 5'd15) || code == 5'd25 || code == 5'd31);
    end else if (ins[26]) begin
      r.regSrc = 2'b01;
      r.immSrc = 2'b10;
      r.e.branch = 1'b1;
      case (ins[25:24])
        2'b00: r.e.aluCtrl = 6'd0;
        2'b01: r.e.aluCtrl = 6'd1;
        2'b10: r.e.aluCtrl = 6'd19;
        default: r.e.aluCtrl = 6'd18;
      endcase
    end else begin
      r.regSrc = {~ins[20], 1'b0};
      r.immSrc = 2'b01;
      r.e.aluSrc = 1'b1;
      r.e.memtoReg = ins[20];
      r.e.regWrite = ins[20];
      r.e.memWrite = ~ins[20];
      r.e.aluCtrl = (sub >= 4'd14) ? 6'd16 + {5'd0, sub[0]} : {2'b00, sub} + 6'd2;
    end
    r.e.pcSrc = r.e.branch | (r.e.regWrite & (ins[15:12] == 4'(`CTRL_PC_REG)));
    return r;
  endfunction

  // Reference model advances on the same edge as the DUT
  always @(posedge clk) begin : refModel
    logic ex;
    decT  dec;
    ex = predictCond(eQ.cond, flagsRef);
    dec = predictDecode(instrD);
    if (!rstN) begin
      eQ = '0;
      mQ = '0;
      wQ = '0;
      flagsRef = '0;
    end else begin
      if (ex && eQ.flagWrite[1]) begin
        flagsRef.n = aluFlagsE.n;
        flagsRef.z = aluFlagsE.z;
      end
      if (ex && eQ.flagWrite[0]) begin
        flagsRef.c = aluFlagsE.c;
        flagsRef.v = aluFlagsE.v;
      end
      wQ = '{memtoReg: mQ.memtoReg, regWrite: mQ.regWrite, pcSrc: mQ.pcSrc};
      mQ = '{memWrite: eQ.memWrite & ex, memtoReg: eQ.memtoReg,
             regWrite: eQ.regWrite & ex, pcSrc: eQ.pcSrc & ex};
      eQ = dec.e;
      if (flushE) begin
        eQ.flagWrite = 2'b00;
        {eQ.branch, eQ.memWrite, eQ.regWrite, eQ.pcSrc, eQ.memtoReg} = 5'b0;
      end
    end
  end

  task automatic stopOnFailure();
    finished = 1'b1;
    $display("TB FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic checkAlu(input string name, input aluCtrlT exp, input aluCtrlT act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      stopOnFailure();
    end
  endtask

  task automatic checkSrc(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      stopOnFailure();
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      stopOnFailure();
    end
  endtask

  task automatic checkFlagBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %b, got %b, model NZCV %b",
               $time, name, exp, act, flagsRef);
      stopOnFailure();
    end
  endtask

  task automatic checkOutputs();
    decT  dec;
    logic ex;
    dec = predictDecode(instrD);
    ex = predictCond(eQ.cond, flagsRef);
    checkSrc("regSrcD", dec.regSrc, regSrcD);
    checkSrc("immSrcD", dec.immSrc, immSrcD);
    checkBit("pcWrPendingF", dec.e.pcSrc | eQ.pcSrc | mQ.pcSrc, pcWrPendingF);
    checkBit("aluSrcE", eQ.aluSrc, aluSrcE);
    checkAlu("aluControlE", eQ.aluCtrl, aluControlE);
    checkBit("memtoRegE", eQ.memtoReg, memtoRegE);
    checkBit("branchTakenE", eQ.branch & ex, branchTakenE);
    checkFlagBit("carryE", flagsRef.c, carryE);
    checkBit("memWriteM", mQ.memWrite, memWriteM);
    checkBit("regWriteM", mQ.regWrite, regWriteM);
    checkBit("memtoRegW", wQ.memtoReg, memtoRegW);
    checkBit("regWriteW", wQ.regWrite, regWriteW);
    checkBit("pcSrcW", wQ.pcSrc, pcSrcW);
  endtask

  task automatic applyStep(input logic [31:12] ins, input flagsT fl, input logic flush);
    @(posedge clk);
    #1;
    instrD = ins;
    aluFlagsE = fl;
    flushE = flush;
    #3;
    checkOutputs();  // Outputs settled by mid-cycle
  endtask

  initial begin
    instrD = '0;
    aluFlagsE = '0;
    flushE = 1'b0;
    seed = 38570;
    cnt = 0;
    while (rstN !== 1'b1) begin
      if (cnt == 40) begin
        $display("Timeout: reset was never released");
        stopOnFailure();
      end else begin
        @(posedge clk);
        #2;
        cnt++;
      end
    end
    checkBit("memWriteM", 1'b0, memWriteM);
    checkBit("regWriteM", 1'b0, regWriteM);
    checkBit("memtoRegW", 1'b0, memtoRegW);
    checkBit("regWriteW", 1'b0, regWriteW);
    checkBit("pcSrcW", 1'b0, pcSrcW);
    checkBit("branchTakenE", 1'b0, branchTakenE);
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      applyStep(DIRECTED[i][24:5], flagsT'(DIRECTED[i][4:1]), DIRECTED[i][0]);
    end
    for (int code = 0; code < 32; code++) begin
      applyStep(dataOp(4'hE, 5'(code), code[1], code[0], 4'(code)), flagsT'(4'(code)), 1'b0);
    end
    for (int s = 0; s < 32; s++) begin
      applyStep(memOp(4'hE, 4'(s), s[4], 4'(s)), '0, 1'b0);
    end
    // Every condition against every flag pattern
    for (int f = 0; f < 16; f++) begin
      for (int c = 0; c < 16; c++) begin
        applyStep(dataOp(4'hE, 5'd4, 1'b0, 1'b1, 4'd1), flagsT'(4'(f)), 1'b0);
        applyStep(dataOp(4'(c), 5'd13, 1'b1, 1'b0, 4'd15), flagsT'(4'(~f)), 1'b0);
        applyStep(memOp(4'(c), 4'd3, 1'b0, 4'd2), '0, 1'b0);
        applyStep(brOp(4'(c), 2'(c)), '0, 1'b0);
      end
    end
    for (int i = 0; i < 200; i++) begin
      rnd = $random(seed);
      applyStep(rnd[19:0], flagsT'(rnd[23:20]), rnd[31:29] == 3'b000);
    end
    cnt = 0;
    while (pcWrPendingF || regWriteM || memWriteM || regWriteW || pcSrcW) begin
      if (cnt == 10) begin
        $display("Timeout: pipeline did not drain");
        stopOnFailure();
      end else begin
        applyStep(memOp(4'hE, 4'd0, 1'b1, 4'd0), '0, 1'b1);
        cnt++;
      end
    end
    finished = 1'b1;
    $display("TB PASSED");
    $finish;
  end

  // Catches a run stopped by a failing assertion
  final begin
    if (!finished) begin
      $display("TB FAILED");
    end
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/ctrlPkg.sv
hw/mainDecoder.sv
hw/aluDecoder.sv
hw/condUnit.sv
hw/pipeReg.sv
hw/controlPipe.sv
hw/controller.sv
verification/controller_asserts.sv
verification/controller_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controller_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG) && ! grep -q "%Error" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
